/* rtl/iq_cfg.svh */
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// Entries held in each of the two interleaved ways
`define IQ_WAY_DEPTH 8

// Per-way pointer width as log2 of the way depth
`define IQ_PTR_W 3

// Occupancy counter holding 0 to 2 * IQ_WAY_DEPTH
`define IQ_CNT_W 5

// Free entries kept back for pushes already in flight.
// Up to two in this cycle, two in decode and two requested,
// so ready drops above 16 - 6 = 10
`define IQ_READY_SLACK 6

`endif

/* rtl/iq_pkg.sv */
package iq_pkg;

  localparam logic [5:0] OP_REG        = 6'd0;
  localparam logic [5:0] OP_ALUI_FIRST = 6'd1;  // Immediate ALU range start
  localparam logic [5:0] OP_ALUI_LAST  = 6'd15;
  localparam logic [5:0] OP_BEQ        = 6'd16;
  localparam logic [5:0] OP_BNE        = 6'd17;
  localparam logic [5:0] OP_LOAD       = 6'd20;
  localparam logic [5:0] OP_STORE      = 6'd21;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [10:0] funct;
  } iq_rform_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [15:0] imm16;
  } iq_iform_t;

  // Same fetched word, two views selected by opcode
  typedef union packed {
    iq_rform_t r;
    iq_iform_t i;
  } iq_inst_u;

  typedef enum logic [2:0] {OPT_NONE, OPT_ALU, OPT_BRANCH, OPT_LOAD, OPT_STORE} iq_optype_e;

  typedef enum logic [1:0] {EXC_NONE, EXC_ILLEGAL, EXC_INT} iq_excp_e;

  typedef struct packed {
    logic [31:0] pc;
    iq_optype_e  optype;
    logic [5:0]  opcode;
    logic [4:0]  dest;
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic [31:0] imm;
    logic        src2_is_imm;
    logic [10:0] funct;
    logic [31:0] br_target;
    logic        have_excp;
    iq_excp_e    excp;
  } iq_uop_t;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
  input  logic [31:0]       i_pc,
  input  iq_pkg::iq_inst_u  i_inst,
  output iq_pkg::iq_uop_t   o_uop
);

  logic [5:0]  opcode;
  logic [31:0] imm_sext;
  logic [31:0] br_offset;

  assign opcode    = i_inst.r.opcode;  // Opcode sits in the same place in both forms
  assign imm_sext  = {{16{i_inst.i.imm16[15]}}, i_inst.i.imm16};
  assign br_offset = {imm_sext[29:0], 2'b00};  // Word offset

  always_comb begin
    o_uop             = '0;
    o_uop.pc          = i_pc;
    o_uop.opcode      = opcode;
    o_uop.optype      = iq_pkg::OPT_NONE;
    o_uop.excp        = iq_pkg::EXC_NONE;

    case (opcode) inside
      iq_pkg::OP_REG: begin
        o_uop.optype = iq_pkg::OPT_ALU;
        o_uop.dest   = i_inst.r.rd;
        o_uop.r1     = i_inst.r.rs1;
        o_uop.r2     = i_inst.r.rs2;
        o_uop.funct  = i_inst.r.funct;
      end

      [iq_pkg::OP_ALUI_FIRST:iq_pkg::OP_ALUI_LAST]: begin
        o_uop.optype      = iq_pkg::OPT_ALU;
        o_uop.dest        = i_inst.i.rd;
        o_uop.r1          = i_inst.i.rs1;
        o_uop.imm         = imm_sext;
        o_uop.src2_is_imm = 1'b1;
      end

      iq_pkg::OP_BEQ, iq_pkg::OP_BNE: begin
        // Second compare operand lives in the rd field
        o_uop.optype    = iq_pkg::OPT_BRANCH;
        o_uop.r1        = i_inst.i.rs1;
        o_uop.r2        = i_inst.i.rd;
        o_uop.imm       = imm_sext;
        o_uop.br_target = i_pc + 32'd4 + br_offset;
      end

      iq_pkg::OP_LOAD: begin
        o_uop.optype = iq_pkg::OPT_LOAD;
        o_uop.dest   = i_inst.i.rd;
        o_uop.r1     = i_inst.i.rs1;  // Base address
        o_uop.imm    = imm_sext;
      end

      iq_pkg::OP_STORE: begin
        o_uop.optype = iq_pkg::OPT_STORE;
        o_uop.r1     = i_inst.i.rs1;
        o_uop.r2     = i_inst.i.rd;   // Store data register
        o_uop.imm    = imm_sext;
      end

      default: begin
        o_uop.have_excp = 1'b1;
        o_uop.excp      = iq_pkg::EXC_ILLEGAL;
      end
    endcase
  end

endmodule

/* rtl/inst_buffer.sv */
`timescale 1ns/1ns
`include "iq_cfg.svh"

module inst_buffer (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_flush,
  input  logic             i_interrupt,
  input  logic [1:0]       i_size,
  input  iq_pkg::iq_uop_t  i_a_uop,
  input  iq_pkg::iq_uop_t  i_b_uop,
  output logic             o_ready,
  input  logic [1:0]       i_out_size,
  output logic             o_a_valid,
  output iq_pkg::iq_uop_t  o_a_uop,
  output logic             o_b_valid,
  output iq_pkg::iq_uop_t  o_b_uop
);

  localparam int unsigned DEPTH = 2 * `IQ_WAY_DEPTH;
  localparam int unsigned CNT_W = `IQ_CNT_W;
  localparam int unsigned READY_LVL = DEPTH - `IQ_READY_SLACK;

  iq_pkg::iq_uop_t mem [2][`IQ_WAY_DEPTH];  // [way][entry]

  logic [`IQ_PTR_W-1:0] head_ptr [2];
  logic [`IQ_PTR_W-1:0] tail_ptr [2];
  logic                 head_sel;  // Way holding the oldest entry
  logic                 tail_sel;  // Way taking the next push
  logic [CNT_W-1:0]     occ;

  logic [1:0]      head_adv;
  logic [1:0]      tail_adv;
  iq_pkg::iq_uop_t a_in;

  // Interrupt rides on the first instruction of the push
  always_comb begin
    a_in = i_a_uop;
    if (i_interrupt) begin
      a_in.have_excp = 1'b1;
      a_in.excp      = iq_pkg::EXC_INT;
    end
  end

  // Two entries always hit both ways, one entry only the selected way
  assign tail_adv[0] = (i_size == 2'd2) || (i_size == 2'd1 && !tail_sel);
  assign tail_adv[1] = (i_size == 2'd2) || (i_size == 2'd1 && tail_sel);
  assign head_adv[0] = (i_out_size == 2'd2) || (i_out_size == 2'd1 && !head_sel);
  assign head_adv[1] = (i_out_size == 2'd2) || (i_out_size == 2'd1 && head_sel);

  always_ff @(posedge clk) begin
    if (!i_rst_n || i_flush) begin
      head_ptr[0] <= '0;
      head_ptr[1] <= '0;
      tail_ptr[0] <= '0;
      tail_ptr[1] <= '0;
      head_sel    <= 1'b0;
      tail_sel    <= 1'b0;
      occ         <= '0;
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (tail_adv[w])
          tail_ptr[w] <= tail_ptr[w] + 1'b1;
        if (head_adv[w])
          head_ptr[w] <= head_ptr[w] + 1'b1;
      end
      tail_sel <= tail_sel ^ i_size[0];  // Odd count flips the way
      head_sel <= head_sel ^ i_out_size[0];
      occ      <= occ + CNT_W'(i_size) - CNT_W'(i_out_size);
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (i_size != 2'd0)
      mem[tail_sel][tail_ptr[tail_sel]] <= a_in;
    if (i_size == 2'd2)
      mem[~tail_sel][tail_ptr[~tail_sel]] <= i_b_uop;
  end

  assign o_a_uop   = mem[head_sel][head_ptr[head_sel]];
  assign o_b_uop   = mem[~head_sel][head_ptr[~head_sel]];
  assign o_a_valid = occ >= CNT_W'(1);
  assign o_b_valid = occ >= CNT_W'(2);
  assign o_ready   = occ <= CNT_W'(READY_LVL);

  a_size_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_size != 2'd3 && i_out_size != 2'd3)
    else $error("inst_buffer: push or pop size of 3");

  // Issue side may only take what is shown as valid
  a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
    CNT_W'(i_out_size) <= occ)
    else $error("inst_buffer: pop of %0d with occupancy %0d", i_out_size, occ);

  // Fetch kept pushing past the slack after ready fell
  a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
    occ <= CNT_W'(DEPTH))
    else $error("inst_buffer: occupancy %0d above depth", occ);

endmodule

/* rtl/decode_queue_top.sv */
`timescale 1ns/1ns

module decode_queue_top (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic [1:0]        i_size,
  input  logic [31:0]       i_a_pc,
  input  iq_pkg::iq_inst_u  i_a_inst,   // Older instruction
  input  logic [31:0]       i_b_pc,
  input  iq_pkg::iq_inst_u  i_b_inst,
  input  logic              i_flush,
  input  logic              i_interrupt,
  input  logic [1:0]        i_out_size,
  output logic              o_ready,
  output logic              o_a_valid,
  output iq_pkg::iq_uop_t   o_a_uop,
  output logic              o_b_valid,
  output iq_pkg::iq_uop_t   o_b_uop
);

  iq_pkg::iq_uop_t a_uop;
  iq_pkg::iq_uop_t b_uop;

  inst_decoder u_dec_a (
    .i_pc   (i_a_pc),
    .i_inst (i_a_inst),
    .o_uop  (a_uop)
  );

  inst_decoder u_dec_b (
    .i_pc   (i_b_pc),
    .i_inst (i_b_inst),
    .o_uop  (b_uop)
  );

  inst_buffer u_buf (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_flush     (i_flush),
    .i_interrupt (i_interrupt),
    .i_size      (i_size),
    .i_a_uop     (a_uop),
    .i_b_uop     (b_uop),
    .o_ready     (o_ready),
    .i_out_size  (i_out_size),
    .o_a_valid   (o_a_valid),
    .o_a_uop     (o_a_uop),
    .o_b_valid   (o_b_valid),
    .o_b_uop     (o_b_uop)
  );

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen (
  output logic clk,
  output logic o_rst_n
);

  initial begin
    clk     = 1'b0;
    o_rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);  // Release away from the sampling edge
    o_rst_n = 1'b1;
  end

  always #50 clk = ~clk;  // 100 ns period

endmodule

/* sim/tb_decode_queue.sv */
`timescale 1ns/1ns
`include "iq_cfg.svh"

module tb_decode_queue;

  localparam int MAX_CYCLES = 3000;  // About 2200 test cycles plus margin
  localparam int READY_LVL  = 2 * `IQ_WAY_DEPTH - `IQ_READY_SLACK;

  logic            clk;
  logic            rst_n;
  logic [1:0]      size;
  logic [31:0]     a_pc;
  logic [31:0]     a_inst;
  logic [31:0]     b_pc;
  logic [31:0]     b_inst;
  logic            flush;
  logic            interrupt;
  logic [1:0]      out_size;
  logic            ready;
  logic            a_valid;
  logic            b_valid;
  iq_pkg::iq_uop_t a_uop;
  iq_pkg::iq_uop_t b_uop;

  iq_pkg::iq_uop_t model_q[$];
  int              exp_occ;
  iq_pkg::iq_uop_t exp_a_uop;
  iq_pkg::iq_uop_t exp_b_uop;
  int              n_errors;
  int              cycle_cnt;
  logic [31:0]     rng;
  logic [31:0]     pc_cnt;

  clk_gen u_clk (.clk(clk), .o_rst_n(rst_n));

  decode_queue_top uut (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_size      (size),
    .i_a_pc      (a_pc),
    .i_a_inst    (a_inst),
    .i_b_pc      (b_pc),
    .i_b_inst    (b_inst),
    .i_flush     (flush),
    .i_interrupt (interrupt),
    .i_out_size  (out_size),
    .o_ready     (ready),
    .o_a_valid   (a_valid),
    .o_a_uop     (a_uop),
    .o_b_valid   (b_valid),
    .o_b_uop     (b_uop)
  );

  task automatic stop_with_fail();
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    n_errors++;
    $display("Error at %0t ns: %s", $time, msg);
    stop_with_fail();
  endtask

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] make_iform(input logic [5:0] op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [15:0] imm);
    return {op, rd, rs1, imm};
  endfunction

  function automatic logic [31:0] make_rform(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [10:0] funct);
    return {6'd0, rd, rs1, rs2, funct};
  endfunction

  // Random word biased so every opcode class shows up often
  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    logic [31:0] fields;
    logic [5:0]  op;
    r      = next_rand();
    fields = next_rand();
    case (r[2:0])
      3'd0:    op = 6'd0;
      3'd1,
      3'd2:    op = 6'd1 + 6'(r[6:3] % 15);
      3'd3:    op = r[7] ? 6'd17 : 6'd16;
      3'd4:    op = 6'd20;
      3'd5:    op = 6'd21;
      3'd6:    op = r[7] ? 6'd18 : 6'd22 + 6'(r[12:8] % 42);  // Unused opcodes
      default: op = r[31:26];
    endcase
    return {op, fields[25:0]};
  endfunction

  function automatic iq_pkg::iq_uop_t ref_decode(input logic [31:0] pc, input logic [31:0] w);
    iq_pkg::iq_uop_t u;
    logic [5:0]      op;
    logic [31:0]     sext;
    op       = w[31:26];
    sext     = {{16{w[15]}}, w[15:0]};
    u        = '0;
    u.pc     = pc;
    u.opcode = op;
    u.optype = iq_pkg::OPT_NONE;
    u.excp   = iq_pkg::EXC_NONE;
    if (op == 6'd0) begin
      u.optype = iq_pkg::OPT_ALU;
      u.dest   = w[25:21];
      u.r1     = w[20:16];
      u.r2     = w[15:11];
      u.funct  = w[10:0];
    end else if (op <= 6'd15) begin
      u.optype      = iq_pkg::OPT_ALU;
      u.dest        = w[25:21];
      u.r1          = w[20:16];
      u.imm         = sext;
      u.src2_is_imm = 1'b1;
    end else if (op == 6'd16 || op == 6'd17) begin
      u.optype    = iq_pkg::OPT_BRANCH;
      u.r1        = w[20:16];
      u.r2        = w[25:21];
      u.imm       = sext;
      u.br_target = pc + 32'd4 + sext * 32'd4;
    end else if (op == 6'd20) begin
      u.optype = iq_pkg::OPT_LOAD;
      u.dest   = w[25:21];
      u.r1     = w[20:16];
      u.imm    = sext;
    end else if (op == 6'd21) begin
      u.optype = iq_pkg::OPT_STORE;
      u.r1     = w[20:16];
      u.r2     = w[25:21];
      u.imm    = sext;
    end else begin
      u.have_excp = 1'b1;
      u.excp      = iq_pkg::EXC_ILLEGAL;
    end
    return u;
  endfunction

  // Model queue follows the same edge as the DUT
  always @(posedge clk) begin
    iq_pkg::iq_uop_t ua;
    ua = ref_decode(a_pc, a_inst);
    if (interrupt) begin
      ua.have_excp = 1'b1;
      ua.excp      = iq_pkg::EXC_INT;
    end
    if (!rst_n || flush) begin
      model_q.delete();
    end else begin
      for (int k = 0; k < int'(out_size); k++)
        void'(model_q.pop_front());
      if (size != 2'd0)
        model_q.push_back(ua);
      if (size == 2'd2)
        model_q.push_back(ref_decode(b_pc, b_inst));
    end
    exp_occ   = model_q.size();
    exp_a_uop = (exp_occ > 0) ? model_q[0] : '0;
    exp_b_uop = (exp_occ > 1) ? model_q[1] : '0;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      stop_with_fail();
    end
  end

  // Outputs only move on the rising edge, so check them mid-cycle
  a_valid_chk: assert property (@(negedge clk) disable iff (!rst_n)
    a_valid == (exp_occ >= 1))
    else report_error($sformatf("o_a_valid %0b with %0d entries", a_valid, exp_occ));

  b_valid_chk: assert property (@(negedge clk) disable iff (!rst_n)
    b_valid == (exp_occ >= 2))
    else report_error($sformatf("o_b_valid %0b with %0d entries", b_valid, exp_occ));

  ready_chk: assert property (@(negedge clk) disable iff (!rst_n)
    ready == (exp_occ <= READY_LVL))
    else report_error($sformatf("o_ready %0b with %0d entries", ready, exp_occ));

  a_uop_chk: assert property (@(negedge clk) disable iff (!rst_n)
    exp_occ < 1 || a_uop == exp_a_uop)
    else report_error($sformatf("o_a_uop %h expected %h", a_uop, exp_a_uop));

  b_uop_chk: assert property (@(negedge clk) disable iff (!rst_n)
    exp_occ < 2 || b_uop == exp_b_uop)
    else report_error($sformatf("o_b_uop %h expected %h", b_uop, exp_b_uop));

  // Push held back above the ready level, pop bounded by the model
  task automatic drive(input int n_in, input int n_out, input logic irq, input logic fl,
                       input logic [31:0] wa, input logic [31:0] wb);
    int n_push;
    int n_pop;
    @(negedge clk);
    n_push    = (exp_occ > READY_LVL) ? 0 : n_in;
    n_pop     = (n_out > exp_occ) ? exp_occ : n_out;
    size      = 2'(n_push);
    out_size  = 2'(n_pop);
    interrupt = irq;
    flush     = fl;
    a_inst    = wa;
    b_inst    = wb;
    a_pc      = pc_cnt;
    b_pc      = pc_cnt + 32'd4;
    pc_cnt    = pc_cnt + 32'(4 * n_push);
  endtask

  task automatic drain();
    repeat (7) drive(0, 2, 1'b0, 1'b0, 32'h0, 32'h0);
  endtask

  initial begin
    size      = '0;
    a_pc      = '0;
    a_inst    = '0;
    b_pc      = '0;
    b_inst    = '0;
    flush     = 1'b0;
    interrupt = 1'b0;
    out_size  = '0;
    exp_occ   = 0;
    exp_a_uop = '0;
    exp_b_uop = '0;
    n_errors  = 0;
    cycle_cnt = 0;
    rng       = 32'd81097;
    pc_cnt    = 32'h0000_1000;

    wait (rst_n);
    repeat (2) drive(0, 0, 1'b0, 1'b0, 32'h0, 32'h0);

    // Directed decode of each opcode class
    drive(2, 0, 1'b0, 1'b0, make_rform(5'd5, 5'd6, 5'd7, 11'h5a5),
          make_iform(6'd3, 5'd9, 5'd10, 16'hfff0));
    drive(2, 1, 1'b0, 1'b0, make_iform(6'd15, 5'd1, 5'd2, 16'h7fff),
          make_iform(6'd16, 5'd3, 5'd4, 16'hfffc));
    drive(2, 1, 1'b0, 1'b0, make_iform(6'd17, 5'd8, 5'd1, 16'h0010),
          make_iform(6'd20, 5'd11, 5'd12, 16'h8000));
    drive(2, 2, 1'b0, 1'b0, make_iform(6'd21, 5'd13, 5'd14, 16'hff00),
          make_iform(6'd18, 5'd1, 5'd1, 16'h1234));
    drive(1, 1, 1'b0, 1'b0, make_iform(6'd63, 5'd2, 5'd3, 16'h0001), 32'h0);
    drain();

    // Fill to 12 then drain one at a time
    repeat (7) drive(2, 0, 1'b0, 1'b0, rand_word(), rand_word());
    repeat (13) drive(0, 1, 1'b0, 1'b0, 32'h0, 32'h0);

    // Interrupt only marks slot a
    drive(2, 0, 1'b1, 1'b0, rand_word(), rand_word());
    drive(1, 0, 1'b1, 1'b0, rand_word(), rand_word());
    drive(2, 1, 1'b0, 1'b0, rand_word(), rand_word());
    drain();

    // Flush alone, then flush with push and pop
    repeat (3) drive(2, 0, 1'b0, 1'b0, rand_word(), rand_word());
    drive(0, 0, 1'b0, 1'b1, 32'h0, 32'h0);
    repeat (2) drive(2, 0, 1'b0, 1'b0, rand_word(), rand_word());
    drive(2, 1, 1'b0, 1'b1, rand_word(), rand_word());
    drive(2, 0, 1'b0, 1'b0, rand_word(), rand_word());
    drive(1, 1, 1'b0, 1'b0, rand_word(), rand_word());
    drain();

    repeat (2000) begin
      logic [31:0] r;
      r = next_rand();
      drive(int'(r[1:0] % 3), int'(r[3:2] % 3), r[7:4] == 4'd0, r[15:10] == 6'd0,
            rand_word(), rand_word());
    end
    drain();
    repeat (2) drive(0, 0, 1'b0, 1'b0, 32'h0, 32'h0);

    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_with_fail();
    end
  end

endmodule

/* flist.f */
+incdir+rtl
rtl/iq_pkg.sv
rtl/inst_decoder.sv
rtl/inst_buffer.sv
rtl/decode_queue_top.sv
sim/clk_gen.sv
sim/tb_decode_queue.sv

/* run.sh */
#!/bin/bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_decode_queue -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
! grep -q "TEST RESULT: FAIL" sim.log && grep -q "TEST RESULT: PASS" sim.log || exit 1
